// File: rtl/mask_ctrl_pkg.sv
// Shared widths, enums and header/config structs for the pipe mask controller
package mask_ctrl_pkg;

    // ==========================================================
    // Widths
    // ==========================================================
    localparam int pipe_count = 4;

    typedef logic [pipe_count-1:0] pipe_bitmap_t;
    typedef logic [5:0]            datatype_t;
    typedef logic [15:0]           pkt_count_t;

    // Short packet datatypes
    localparam datatype_t DT_FRAME_START = 6'h00;
    localparam datatype_t DT_FRAME_END   = 6'h01;

    // ==========================================================
    // Enums
    // ==========================================================
    typedef enum logic [1:0] {
        AGGR_SYNC = 2'd1
    } aggr_mode_e;

    typedef enum logic [1:0] {
        WR_DROP  = 2'd0,
        WR_STORE = 2'd2
    } wr_mode_e;

    typedef enum logic [2:0] {
        MS_INIT         = 3'd0,
        MS_IDLE         = 3'd1,
        MS_STATUS_CHECK = 3'd2,
        MS_MASK_RECOVER = 3'd3,
        MS_MASK_TIMEOUT = 3'd4,
        MS_CLEAR_MASK   = 3'd5,
        MS_SCHEDULING   = 3'd6
    } mask_state_e;

    typedef enum logic [1:0] {
        FP_IDLE        = 2'd0,
        FP_FRAME_START = 2'd1,
        FP_LONG_LINE   = 2'd2,
        FP_FRAME_END   = 2'd3
    } frame_pos_e;

    // ==========================================================
    // Structs
    // ==========================================================
    typedef struct packed {
        datatype_t  datatype;
        pkt_count_t count;
    } pkt_hdr_t;

    typedef struct packed {
        pipe_bitmap_t concat_en;
        pipe_bitmap_t force_mask;
        pipe_bitmap_t auto_mask_en;
        pipe_bitmap_t restart_en;
    } mask_cfg_t;

    typedef struct packed {
        datatype_t  long_datatype;
        pkt_count_t last_line;
        logic       check_frame_en;
        logic       check_line_en;
    } frame_cfg_t;

endpackage

// File: rtl/mask_state_fsm.sv
// Round FSM with check window, config latch, mask bitmap, clear/schedule pulses, write modes
module mask_state_fsm #(
    parameter int CHECK_CYCLES = 3
) (
    input  logic                                                   clk,
    input  logic                                                   rst_n,
    input  mask_ctrl_pkg::mask_cfg_t                               mask_cfg,
    input  mask_ctrl_pkg::pipe_bitmap_t                            pipe_frame_active,
    input  logic                                                   frame_sync_lock,
    input  mask_ctrl_pkg::aggr_mode_e                              aggre_mode,
    input  logic                                                   mask_latch_reset,
    input  mask_ctrl_pkg::pipe_bitmap_t                            hdr_valid,
    input  mask_ctrl_pkg::pipe_bitmap_t                            pass_bitmap,
    input  mask_ctrl_pkg::pipe_bitmap_t                            fail_bitmap,
    input  logic                                                   end_sch_pulse,
    output mask_ctrl_pkg::mask_state_e                             state,
    output mask_ctrl_pkg::pipe_bitmap_t                            mask_bitmap,
    output mask_ctrl_pkg::pipe_bitmap_t                            normal_bitmap,
    output mask_ctrl_pkg::pipe_bitmap_t                            restart_bitmap,
    output mask_ctrl_pkg::pipe_bitmap_t                            auto_mask_en,
    output mask_ctrl_pkg::pipe_bitmap_t                            pipe_clear_pulse,
    output logic                                                   start_sch_pulse,
    output mask_ctrl_pkg::wr_mode_e [mask_ctrl_pkg::pipe_count-1:0] wr_mode
);
    import mask_ctrl_pkg::*;

    localparam int CNT_W = $clog2(CHECK_CYCLES + 1);

    mask_state_e      next_state;
    logic [CNT_W-1:0] check_cnt;
    logic             check_done;
    logic             round_start;
    pipe_bitmap_t     mask_next;

    // Enabled and unmasked pipes take part normally
    assign normal_bitmap  = mask_cfg.concat_en & ~mask_bitmap;
    // Masked pipes that may come back
    assign restart_bitmap = mask_bitmap & mask_cfg.restart_en & pipe_frame_active;

    assign round_start = |((normal_bitmap | restart_bitmap) & hdr_valid);
    assign check_done  = (check_cnt == CNT_W'(CHECK_CYCLES - 1));

    // ==========================================================
    // Next state
    // ==========================================================
    always_comb begin
        next_state = state;
        case (state)
            MS_INIT: begin
                if (aggre_mode == AGGR_SYNC && frame_sync_lock) begin
                    next_state = MS_IDLE;
                end
            end
            MS_IDLE: begin
                if (mask_latch_reset) begin
                    next_state = MS_INIT;
                end else if (round_start) begin
                    next_state = MS_STATUS_CHECK;
                end
            end
            MS_STATUS_CHECK: begin
                if (check_done) begin
                    next_state = MS_MASK_RECOVER;
                end
            end
            MS_MASK_RECOVER: next_state = MS_MASK_TIMEOUT;
            MS_MASK_TIMEOUT: next_state = MS_CLEAR_MASK;
            MS_CLEAR_MASK: begin
                // All pipes lost, start over from config
                if (&mask_bitmap) begin
                    next_state = MS_INIT;
                end else if (|pass_bitmap) begin
                    next_state = MS_SCHEDULING;
                end else begin
                    next_state = MS_IDLE;
                end
            end
            MS_SCHEDULING: begin
                if (end_sch_pulse) begin
                    next_state = MS_IDLE;
                end
            end
            default: next_state = MS_INIT;
        endcase
    end

    // Mask update per state
    always_comb begin
        case (state)
            MS_INIT:         mask_next = mask_cfg.concat_en & mask_cfg.force_mask;
            MS_MASK_RECOVER: mask_next = mask_bitmap & ~(restart_bitmap & pass_bitmap);
            MS_MASK_TIMEOUT: mask_next = mask_bitmap | (normal_bitmap & fail_bitmap);
            default:         mask_next = mask_bitmap;
        endcase
    end

    // ==========================================================
    // Registers
    // ==========================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state            <= MS_INIT;
            check_cnt        <= '0;
            mask_bitmap      <= '1;
            auto_mask_en     <= '0;
            pipe_clear_pulse <= '0;
            start_sch_pulse  <= 1'b0;
        end else begin
            state       <= next_state;
            mask_bitmap <= mask_next;
            if (state == MS_STATUS_CHECK && !check_done) begin
                check_cnt <= check_cnt + 1'b1;
            end else begin
                check_cnt <= '0;
            end
            if (state == MS_INIT) begin
                auto_mask_en <= mask_cfg.auto_mask_en;
            end
            // Clear pulse carries the mask after the timeout update
            pipe_clear_pulse <= (next_state == MS_CLEAR_MASK) ? mask_next : '0;
            start_sch_pulse  <= (state == MS_CLEAR_MASK) && (next_state == MS_SCHEDULING);
        end
    end

    // Write mode per pipe
    always_comb begin
        for (int i = 0; i < pipe_count; i++) begin
            if (state == MS_INIT || (mask_bitmap[i] && !mask_cfg.restart_en[i])) begin
                wr_mode[i] = WR_DROP;
            end else begin
                wr_mode[i] = WR_STORE;
            end
        end
    end

    a_sch_single: assert property (@(posedge clk) disable iff (!rst_n)
        start_sch_pulse |=> !start_sch_pulse);

    a_clear_in_state: assert property (@(posedge clk) disable iff (!rst_n)
        (pipe_clear_pulse != '0) |-> (state == MS_CLEAR_MASK));

endmodule

// File: rtl/frame_position_tracker.sv
// Local frame position tracker with line and frame counters and expected header
module frame_position_tracker (
    input  logic                       clk,
    input  logic                       rst_n,
    input  mask_ctrl_pkg::mask_state_e state,
    input  logic                       start_sch_pulse,
    input  mask_ctrl_pkg::frame_cfg_t  frame_cfg,
    output mask_ctrl_pkg::pkt_hdr_t    expected_hdr,
    output logic                       check_count,
    output mask_ctrl_pkg::pkt_count_t  frame_count,
    output mask_ctrl_pkg::pkt_count_t  line_count,
    output mask_ctrl_pkg::frame_pos_e  position
);
    import mask_ctrl_pkg::*;

    logic is_short;
    logic is_long;

    // Position only moves on a scheduled round
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            position    <= FP_IDLE;
            frame_count <= '0;
            line_count  <= '0;
        end else if (state == MS_INIT) begin
            position    <= FP_IDLE;
            frame_count <= '0;
        end else begin
            case (position)
                FP_IDLE: position <= FP_FRAME_START;
                FP_FRAME_START: begin
                    if (start_sch_pulse) begin
                        line_count <= '0;
                        position   <= FP_LONG_LINE;
                    end
                end
                FP_LONG_LINE: begin
                    if (start_sch_pulse) begin
                        line_count <= line_count + 1'b1;
                        // Last line of the frame
                        if (line_count == frame_cfg.last_line) begin
                            position <= FP_FRAME_END;
                        end
                    end
                end
                FP_FRAME_END: begin
                    if (start_sch_pulse) begin
                        frame_count <= frame_count + 1'b1;
                        position    <= FP_FRAME_START;
                    end
                end
                default: position <= FP_IDLE;
            endcase
        end
    end

    assign is_short = (position == FP_FRAME_START) || (position == FP_FRAME_END);
    assign is_long  = (position == FP_LONG_LINE);

    // ==========================================================
    // Expected header
    // ==========================================================
    always_comb begin
        case (position)
            FP_FRAME_END: expected_hdr.datatype = DT_FRAME_END;
            FP_LONG_LINE: expected_hdr.datatype = frame_cfg.long_datatype;
            default:      expected_hdr.datatype = DT_FRAME_START;
        endcase
        if (is_long) begin
            expected_hdr.count = line_count;
        end else if (is_short) begin
            expected_hdr.count = frame_count;
        end else begin
            expected_hdr.count = '0;
        end
    end

    assign check_count = (is_short && frame_cfg.check_frame_en) ||
                         (is_long && frame_cfg.check_line_en);

    a_idle_in_init: assert property (@(posedge clk) disable iff (!rst_n)
        (state == MS_INIT) |=> (position == FP_IDLE));

endmodule

// File: rtl/pipe_status_checker.sv
// Per-pipe header check against the expected position, pass/fail bitmaps, header accept
module pipe_status_checker (
    input  logic                                                   clk,
    input  logic                                                   rst_n,
    input  mask_ctrl_pkg::mask_state_e                             state,
    input  mask_ctrl_pkg::pipe_bitmap_t                            hdr_valid,
    input  mask_ctrl_pkg::pkt_hdr_t [mask_ctrl_pkg::pipe_count-1:0] hdr,
    input  mask_ctrl_pkg::pkt_hdr_t                                expected_hdr,
    input  logic                                                   check_count,
    input  mask_ctrl_pkg::pipe_bitmap_t                            normal_bitmap,
    input  mask_ctrl_pkg::pipe_bitmap_t                            restart_bitmap,
    input  mask_ctrl_pkg::pipe_bitmap_t                            auto_mask_en,
    output mask_ctrl_pkg::pipe_bitmap_t                            hdr_ready,
    output mask_ctrl_pkg::pipe_bitmap_t                            pass_bitmap,
    output mask_ctrl_pkg::pipe_bitmap_t                            fail_bitmap
);
    import mask_ctrl_pkg::*;

    pipe_bitmap_t pass_now;
    pipe_bitmap_t fail_now;
    pipe_bitmap_t valid_q;
    logic         in_check_q;
    logic         sample;

    // Header compare for every pipe
    always_comb begin
        for (int i = 0; i < pipe_count; i++) begin
            pass_now[i] = (normal_bitmap[i] || restart_bitmap[i]) && hdr_valid[i] &&
                          (hdr[i].datatype == expected_hdr.datatype) &&
                          (!check_count || hdr[i].count == expected_hdr.count);
            // Offered header that does not match
            fail_now[i] = normal_bitmap[i] && hdr_valid[i] && !pass_now[i] &&
                          auto_mask_en[i];
        end
    end

    // First cycle of the check window
    assign sample = (state == MS_STATUS_CHECK) && !in_check_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_check_q  <= 1'b0;
            valid_q     <= '0;
            pass_bitmap <= '0;
            fail_bitmap <= '0;
        end else begin
            in_check_q <= (state == MS_STATUS_CHECK);
            if (sample) begin
                valid_q     <= hdr_valid;
                pass_bitmap <= pass_now;
                fail_bitmap <= fail_now;
            end
        end
    end

    // Every offered header is consumed in the clear cycle
    assign hdr_ready = (state == MS_CLEAR_MASK) ? valid_q : '0;

    a_ready_valid: assert property (@(posedge clk) disable iff (!rst_n)
        (hdr_ready & ~hdr_valid) == '0);

    a_pass_fail: assert property (@(posedge clk) disable iff (!rst_n)
        (pass_bitmap & fail_bitmap) == '0);

endmodule

// File: rtl/pipe_mask_top.sv
// Top level of the mask controller with FSM, frame tracker and status checker
module pipe_mask_top #(
    parameter int CHECK_CYCLES = 3
) (
    input  logic                                                   clk,
    input  logic                                                   rst_n,
    input  mask_ctrl_pkg::mask_cfg_t                               mask_cfg,
    input  mask_ctrl_pkg::frame_cfg_t                              frame_cfg,
    input  mask_ctrl_pkg::pipe_bitmap_t                            pipe_frame_active,
    input  logic                                                   frame_sync_lock,
    input  mask_ctrl_pkg::aggr_mode_e                              aggre_mode,
    input  logic                                                   mask_latch_reset,
    input  mask_ctrl_pkg::pipe_bitmap_t                            hdr_valid,
    input  mask_ctrl_pkg::pkt_hdr_t [mask_ctrl_pkg::pipe_count-1:0] hdr,
    input  logic                                                   end_sch_pulse,
    output mask_ctrl_pkg::pipe_bitmap_t                            hdr_ready,
    output logic                                                   start_sch_pulse,
    output mask_ctrl_pkg::pipe_bitmap_t                            pipe_clear_pulse,
    output mask_ctrl_pkg::wr_mode_e [mask_ctrl_pkg::pipe_count-1:0] wr_mode,
    output mask_ctrl_pkg::pipe_bitmap_t                            mask_bitmap,
    output mask_ctrl_pkg::pkt_count_t                              frame_count,
    output mask_ctrl_pkg::pkt_count_t                              line_count,
    output mask_ctrl_pkg::datatype_t                               pkt_datatype
);
    import mask_ctrl_pkg::*;

    mask_state_e  state;
    pipe_bitmap_t normal_bitmap;
    pipe_bitmap_t restart_bitmap;
    pipe_bitmap_t auto_mask_en;
    pipe_bitmap_t pass_bitmap;
    pipe_bitmap_t fail_bitmap;
    pkt_hdr_t     expected_hdr;
    logic         check_count;

    assign pkt_datatype = expected_hdr.datatype;

    mask_state_fsm #(
        .CHECK_CYCLES(CHECK_CYCLES)
    ) mask_state_fsm_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .mask_cfg         (mask_cfg),
        .pipe_frame_active(pipe_frame_active),
        .frame_sync_lock  (frame_sync_lock),
        .aggre_mode       (aggre_mode),
        .mask_latch_reset (mask_latch_reset),
        .hdr_valid        (hdr_valid),
        .pass_bitmap      (pass_bitmap),
        .fail_bitmap      (fail_bitmap),
        .end_sch_pulse    (end_sch_pulse),
        .state            (state),
        .mask_bitmap      (mask_bitmap),
        .normal_bitmap    (normal_bitmap),
        .restart_bitmap   (restart_bitmap),
        .auto_mask_en     (auto_mask_en),
        .pipe_clear_pulse (pipe_clear_pulse),
        .start_sch_pulse  (start_sch_pulse),
        .wr_mode          (wr_mode)
    );

    frame_position_tracker frame_position_tracker_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .state          (state),
        .start_sch_pulse(start_sch_pulse),
        .frame_cfg      (frame_cfg),
        .expected_hdr   (expected_hdr),
        .check_count    (check_count),
        .frame_count    (frame_count),
        .line_count     (line_count),
        .position       ()
    );

    pipe_status_checker pipe_status_checker_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .state         (state),
        .hdr_valid     (hdr_valid),
        .hdr           (hdr),
        .expected_hdr  (expected_hdr),
        .check_count   (check_count),
        .normal_bitmap (normal_bitmap),
        .restart_bitmap(restart_bitmap),
        .auto_mask_en  (auto_mask_en),
        .hdr_ready     (hdr_ready),
        .pass_bitmap   (pass_bitmap),
        .fail_bitmap   (fail_bitmap)
    );

endmodule

// File: verification/pipe_mask_tb.sv
// Testbench for the pipe mask controller with file-driven rounds, checks and watchdog
module pipe_mask_tb;
    import mask_ctrl_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int ROUND_CYCLES = 30;
    localparam int NUM_FIELDS   = 17;

    // Fixed configuration for the whole run
    localparam pipe_bitmap_t CONCAT_EN    = 4'hf;
    localparam pipe_bitmap_t FORCE_MASK   = 4'h8;
    localparam pipe_bitmap_t AUTO_MASK_EN = 4'hf;
    localparam pipe_bitmap_t RESTART_EN   = 4'h8;
    localparam pipe_bitmap_t FRAME_ACTIVE = 4'h8;

    typedef struct packed {
        logic                        latch_reset;
        pipe_bitmap_t                valid;
        pkt_hdr_t [pipe_count-1:0]   hdrs;
        datatype_t                   exp_datatype;
        pkt_count_t                  exp_line;
        pkt_count_t                  exp_frame;
        pipe_bitmap_t                pre_mask;
        pipe_bitmap_t                exp_mask;
        pipe_bitmap_t                exp_ready;
        logic                        exp_sch;
    } stim_rec_t;

    logic                      clk;
    logic                      rst_n;
    mask_cfg_t                 mask_cfg;
    frame_cfg_t                frame_cfg;
    pipe_bitmap_t              pipe_frame_active;
    logic                      frame_sync_lock;
    aggr_mode_e                aggre_mode;
    logic                      mask_latch_reset;
    pipe_bitmap_t              hdr_valid;
    pkt_hdr_t [pipe_count-1:0] hdr;
    logic                      end_sch_pulse;
    pipe_bitmap_t              hdr_ready;
    logic                      start_sch_pulse;
    pipe_bitmap_t              pipe_clear_pulse;
    wr_mode_e [pipe_count-1:0] wr_mode;
    pipe_bitmap_t              mask_bitmap;
    pkt_count_t                frame_count;
    pkt_count_t                line_count;
    datatype_t                 pkt_datatype;

    stim_rec_t recs[$];
    int        num_recs = 0;
    int        errors = 0;
    integer    seed = 43069;

    pipe_mask_top #(
        .CHECK_CYCLES(3)
    ) pipe_mask_top_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .mask_cfg         (mask_cfg),
        .frame_cfg        (frame_cfg),
        .pipe_frame_active(pipe_frame_active),
        .frame_sync_lock  (frame_sync_lock),
        .aggre_mode       (aggre_mode),
        .mask_latch_reset (mask_latch_reset),
        .hdr_valid        (hdr_valid),
        .hdr              (hdr),
        .end_sch_pulse    (end_sch_pulse),
        .hdr_ready        (hdr_ready),
        .start_sch_pulse  (start_sch_pulse),
        .pipe_clear_pulse (pipe_clear_pulse),
        .wr_mode          (wr_mode),
        .mask_bitmap      (mask_bitmap),
        .frame_count      (frame_count),
        .line_count       (line_count),
        .pkt_datatype     (pkt_datatype)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ==========================================================
    // Helpers
    // ==========================================================
    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("Mismatch at time %0t: %s is %0h, expected %0h", $time, what, actual,
                     expected);
            $display("STATUS: FAIL");
            $fatal(1, "Check failed");
        end
    endtask

    // Masked pipes without restart lose their data
    function automatic wr_mode_e expected_wr_mode(input pipe_bitmap_t mask, input int pipe);
        if (mask[pipe] && !RESTART_EN[pipe]) begin
            return WR_DROP;
        end
        return WR_STORE;
    endfunction

    task automatic check_wr_modes(input pipe_bitmap_t mask);
        for (int p = 0; p < pipe_count; p++) begin
            check_value($sformatf("wr_mode[%0d]", p), 32'(wr_mode[p]),
                        32'(expected_wr_mode(mask, p)));
        end
    endtask

    task automatic read_stimulus();
        int          fd;
        int          nfields;
        string       line;
        logic [31:0] fld [NUM_FIELDS];
        stim_rec_t   rec;
        fd = $fopen("verification/pipe_mask_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file verification/pipe_mask_stim.txt");
            $display("STATUS: FAIL");
            $fatal(1, "No stimulus");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            nfields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                              fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6],
                              fld[7], fld[8], fld[9], fld[10], fld[11], fld[12], fld[13],
                              fld[14], fld[15], fld[16]);
            if (nfields != NUM_FIELDS) begin
                $display("Stimulus line has %0d fields instead of %0d", nfields, NUM_FIELDS);
                $display("STATUS: FAIL");
                $fatal(1, "Bad stimulus line");
            end
            rec.latch_reset = fld[0][0];
            rec.valid       = fld[1][pipe_count-1:0];
            for (int p = 0; p < pipe_count; p++) begin
                rec.hdrs[p].datatype = fld[2 + 2 * p][5:0];
                rec.hdrs[p].count    = fld[3 + 2 * p][15:0];
            end
            rec.exp_datatype = fld[10][5:0];
            rec.exp_line     = fld[11][15:0];
            rec.exp_frame    = fld[12][15:0];
            rec.pre_mask     = fld[13][pipe_count-1:0];
            rec.exp_mask     = fld[14][pipe_count-1:0];
            rec.exp_ready    = fld[15][pipe_count-1:0];
            rec.exp_sch      = fld[16][0];
            recs.push_back(rec);
        end
        $fclose(fd);
        if (recs.size() == 0) begin
            $display("The stimulus file holds no records");
            $display("STATUS: FAIL");
            $fatal(1, "Empty stimulus");
        end
        num_recs = recs.size();
    endtask

    // Back to MS_INIT from idle, then relock and frame start
    task automatic pulse_latch_reset();
        @(posedge clk);
        mask_latch_reset <= 1'b1;
        @(posedge clk);
        mask_latch_reset <= 1'b0;
        repeat (3) @(posedge clk);
    endtask

    task automatic answer_scheduler();
        int delay;
        delay = 1 + int'($unsigned($random(seed)) % 4);
        repeat (delay) @(posedge clk);
        end_sch_pulse <= 1'b1;
        @(posedge clk);
        end_sch_pulse <= 1'b0;
    endtask

    // ==========================================================
    // One round per record
    // ==========================================================
    task automatic run_round(input stim_rec_t r);
        if (r.latch_reset) begin
            pulse_latch_reset();
        end
        @(negedge clk);
        check_value("pkt_datatype", 32'(pkt_datatype), 32'(r.exp_datatype));
        check_value("line_count", 32'(line_count), 32'(r.exp_line));
        check_value("frame_count", 32'(frame_count), 32'(r.exp_frame));
        check_value("mask_bitmap before round", 32'(mask_bitmap), 32'(r.pre_mask));
        check_wr_modes(r.pre_mask);
        @(posedge clk);
        hdr_valid <= r.valid;
        hdr       <= r.hdrs;
        // Six edges later the FSM sits in MS_CLEAR_MASK
        repeat (6) @(posedge clk);
        @(negedge clk);
        check_value("hdr_ready", 32'(hdr_ready), 32'(r.exp_ready));
        check_value("pipe_clear_pulse", 32'(pipe_clear_pulse), 32'(r.exp_mask));
        check_wr_modes(r.exp_mask);
        @(posedge clk);
        hdr_valid <= '0;
        @(negedge clk);
        check_value("start_sch_pulse", 32'(start_sch_pulse), 32'(r.exp_sch));
        check_value("mask_bitmap after round", 32'(mask_bitmap), 32'(r.exp_mask));
        if (r.exp_sch) begin
            answer_scheduler();
        end
        repeat (3) @(posedge clk);
    endtask

    initial begin
        wait (num_recs > 0);
        #(num_recs * ROUND_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before all rounds were done");
        $display("STATUS: FAIL");
        $fatal(1, "Timeout");
    end

    initial begin
        rst_n             = 1'b0;
        mask_cfg          = '{concat_en: CONCAT_EN, force_mask: FORCE_MASK,
                              auto_mask_en: AUTO_MASK_EN, restart_en: RESTART_EN};
        frame_cfg         = '{long_datatype: 6'h2b, last_line: 16'd1,
                              check_frame_en: 1'b1, check_line_en: 1'b1};
        pipe_frame_active = FRAME_ACTIVE;
        frame_sync_lock   = 1'b1;
        aggre_mode        = AGGR_SYNC;
        mask_latch_reset  = 1'b0;
        hdr_valid         = '0;
        hdr               = '0;
        end_sch_pulse     = 1'b0;
        read_stimulus();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        // Leave MS_INIT and reach frame start
        repeat (4) @(posedge clk);
        foreach (recs[n]) begin
            run_round(recs[n]);
        end
        if (errors == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("STATUS: FAIL");
            $fatal(1, "Checks failed");
        end
    end

endmodule

// File: verification/pipe_mask_stim.txt
# Columns: latch_reset valid hdr0_dt hdr0_cnt hdr1_dt hdr1_cnt hdr2_dt hdr2_cnt hdr3_dt hdr3_cnt
# then exp_datatype exp_line exp_frame pre_mask exp_mask exp_ready exp_sch (all hex)
# Frame start, pipe 3 recovers from force mask
0 f 00 0000 00 0000 00 0000 00 0000 00 0000 0000 8 0 f 1
# Line 0, pipe 2 wrong datatype
0 f 2b 0000 2b 0000 2c 0000 2b 0000 2b 0000 0000 0 4 f 1
# Line 1, pipe 1 wrong count
0 b 2b 0001 2b 0002 00 0000 2b 0001 2b 0001 0000 4 6 b 1
# Frame end
0 9 01 0000 00 0000 00 0000 01 0000 01 0002 0000 6 6 9 1
# Latch reset in idle, then frame start again
1 f 00 0000 00 0000 00 0000 00 0000 00 0002 0000 8 0 f 1
# No pass, round goes back to idle
0 1 2b 0005 00 0000 00 0000 00 0000 2b 0000 0000 0 1 1 0
# Remaining pipes fail, all masked
0 e 00 0000 00 0000 00 0000 00 0000 2b 0000 0000 1 f e 0
# After re-init, pipe 3 masked but still stores
0 7 00 0000 00 0000 00 0000 00 0000 00 0000 0000 8 8 7 1
0 f 2b 0000 2b 0000 2b 0000 2b 0000 2b 0000 0000 8 0 f 1
0 f 2b 0001 2b 0001 2b 0001 2b 0001 2b 0001 0000 0 0 f 1
0 f 01 0000 01 0000 01 0000 01 0000 01 0002 0000 0 0 f 1
0 f 00 0001 00 0001 00 0001 00 0001 00 0002 0001 0 0 f 1

// File: pipe_mask.f
rtl/mask_ctrl_pkg.sv
rtl/mask_state_fsm.sv
rtl/frame_position_tracker.sv
rtl/pipe_status_checker.sv
rtl/pipe_mask_top.sv
verification/pipe_mask_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module pipe_mask_tb \
    -f pipe_mask.f -o pipe_mask_sim

./obj_dir/pipe_mask_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "STATUS: PASS" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
